//--- axil_sub_isolator.f
+incdir+rtl
rtl/axil_iso_pkg.sv
rtl/iso_ctrl_fsm.sv
rtl/iso_resp_tracker.sv
rtl/resp_out_reg.sv
rtl/wr_iso_path.sv
rtl/rd_iso_path.sv
rtl/axil_sub_isolator.sv
sim/axil_iso_asserts.sv
sim/tb_axil_sub_isolator.sv

//--- Makefile
# Verilator simulation of the AXI4-Lite subordinate isolator

TOP = tb_axil_sub_isolator

sim:
	verilator --binary --timing --assert -Mdir obj_dir --top-module $(TOP) -f axil_sub_isolator.f
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf obj_dir

.PHONY: sim clean

//--- sim/tb_axil_sub_isolator.sv
//**************************************************
// Testbench for the AXI4-Lite subordinate isolator:
// clock and reset, a downstream responder model,
// an upstream response collector, directed tests
// for pass-through, isolation, resume and
// backpressure, a timeout and the closing summary
//**************************************************

`timescale 1ns/1ns
`default_nettype none

`include "axil_iso_config.svh"

module tb_axil_sub_isolator
  import axil_iso_pkg::*;
;

  // The directed tests take under a hundred cycles
  localparam int TIMEOUT_CYCLES = 3000;
  localparam resp_t RESP_OKAY = 2'b00;

  logic  clk, rst_n, isolate_req, isolate_done;
  addr_t awaddr, araddr, ds_awaddr, ds_araddr;
  data_t wdata, rdata, ds_wdata, ds_rdata;
  strb_t wstrb, ds_wstrb;
  resp_t bresp, rresp, ds_bresp, ds_rresp;
  logic  awvalid, awready, wvalid, wready, bvalid, bready;
  logic  arvalid, arready, rvalid, rready;
  logic  ds_awvalid, ds_awready, ds_wvalid, ds_wready, ds_bvalid, ds_bready;
  logic  ds_arvalid, ds_arready, ds_rvalid, ds_rready;

  // Responder controls and what it saw on the downstream side
  logic  hold, flush;
  addr_t seen_awaddr;
  data_t seen_wdata;
  strb_t seen_wstrb;
  int    ds_valid_seen;
  // Upstream responses in arrival order
  resp_t b_resp_q[$];
  data_t r_data_q[$];
  resp_t r_resp_q[$];
  int    checks, errors;
  int    cycles = 0;

  axil_sub_isolator dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
  end

  // Downstream subordinate, answers in request order unless held back
  initial begin
    data_t rd_q[$];
    int    b_pending;
    logic  hold_now;
    b_pending = 0;
    {ds_awready, ds_wready, ds_arready} = 3'b111;
    {ds_bvalid, ds_rvalid} = 2'b00;
    ds_bresp = RESP_OKAY;
    ds_rresp = RESP_OKAY;
    ds_rdata = '0;
    forever begin
      @(posedge clk);
      hold_now = hold;
      if (!rst_n || flush) begin
        rd_q.delete();
        b_pending = 0;
      end else begin
        if (ds_bvalid && ds_bready) b_pending--;
        if (ds_rvalid && ds_rready) void'(rd_q.pop_front());
        if (ds_awvalid && ds_awready) begin
          b_pending++;
          seen_awaddr = ds_awaddr;
        end
        if (ds_wvalid && ds_wready) begin
          seen_wdata = ds_wdata;
          seen_wstrb = ds_wstrb;
        end
        if (ds_arvalid && ds_arready) rd_q.push_back(data_t'(ds_araddr) + 32'h1000);
        if (ds_awvalid || ds_wvalid || ds_arvalid) ds_valid_seen++;
      end
      #1;
      ds_bvalid = !hold_now && (b_pending > 0);
      ds_rvalid = !hold_now && (rd_q.size() > 0);
      ds_rdata = (rd_q.size() > 0) ? rd_q[0] : '0;
    end
  end

  always @(posedge clk) begin
    if (rst_n && bvalid && bready) b_resp_q.push_back(bresp);
    if (rst_n && rvalid && rready) begin
      r_data_q.push_back(rdata);
      r_resp_q.push_back(rresp);
    end
  end

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("FAIL %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond === 1'b1) else begin
      $display("Error: %s", what);
      errors++;
    end
  endtask

  task automatic send_write(input addr_t addr, input data_t data, input strb_t strb);
    awaddr = addr;
    wdata = data;
    wstrb = strb;
    awvalid = 1'b1;
    wvalid = 1'b1;
    @(posedge clk);
    while (!(awready && wready)) @(posedge clk);
    #1;
    awvalid = 1'b0;
    wvalid = 1'b0;
  endtask

  task automatic send_read(input addr_t addr);
    araddr = addr;
    arvalid = 1'b1;
    @(posedge clk);
    while (!arready) @(posedge clk);
    #1;
    arvalid = 1'b0;
  endtask

  task automatic wait_responses(input int n_r, input int n_b);
    while (r_data_q.size() < n_r || b_resp_q.size() < n_b) next_cycle();
  endtask

  task automatic wait_done(input logic level);
    while (isolate_done !== level) next_cycle();
  endtask

  task automatic check_read_beat(input data_t exp_data, input resp_t exp_resp);
    check_true(r_data_q.size() > 0, "an expected R beat is missing");
    if (r_data_q.size() > 0) begin
      check_val("rdata", r_data_q.pop_front(), exp_data);
      check_val("rresp", 32'(r_resp_q.pop_front()), 32'(exp_resp));
    end
  endtask

  task automatic check_write_beat(input resp_t exp_resp);
    check_true(b_resp_q.size() > 0, "an expected B beat is missing");
    if (b_resp_q.size() > 0) check_val("bresp", 32'(b_resp_q.pop_front()), 32'(exp_resp));
  endtask

  task automatic flush_responder();
    flush = 1'b1;
    next_cycle();
    flush = 1'b0;
  endtask

  task automatic write_pass_through(input addr_t addr, input data_t data, input strb_t strb);
    send_write(addr, data, strb);
    check_val("ds_awaddr", 32'(seen_awaddr), 32'(addr));
    check_val("ds_wdata", seen_wdata, data);
    check_val("ds_wstrb", 32'(seen_wstrb), 32'(strb));
    wait_responses(0, 1);
    check_write_beat(RESP_OKAY);
  endtask

  task automatic read_pass_through(input addr_t addr);
    send_read(addr);
    wait_responses(1, 0);
    check_read_beat(data_t'(addr) + 32'h1000, RESP_OKAY);
  endtask

  task automatic isolate_with_pending();
    hold = 1'b1;
    for (int i = 0; i < 3; i++) send_read(addr_t'(32'h010 + 4 * i));
    send_write(12'h020, 32'h0bad_0020, 4'hf);
    send_write(12'h024, 32'h0bad_0024, 4'h1);
    // Upstream backpressure keeps the local answers waiting in the output registers
    bready = 1'b0;
    rready = 1'b0;
    isolate_req = 1'b1;
    repeat (4) next_cycle();
    check_true(!isolate_done, "isolate_done rose while local answers were still held");
    bready = 1'b1;
    rready = 1'b1;
    wait_done(1'b1);
    // Every pending request is answered before done rises
    check_val("R beats at isolate_done", 32'(r_data_q.size()), 32'd3);
    check_val("B beats at isolate_done", 32'(b_resp_q.size()), 32'd2);
    for (int i = 0; i < 3; i++) check_read_beat(`AXIL_ISO_RDATA, `AXIL_ISO_RESP_SLVERR);
    for (int i = 0; i < 2; i++) check_write_beat(`AXIL_ISO_RESP_SLVERR);
  endtask

  task automatic isolated_traffic();
    int seen_before;
    seen_before = ds_valid_seen;
    send_read(12'h030);
    send_write(12'h034, 32'h5555_aaaa, 4'h3);
    wait_responses(1, 1);
    check_read_beat(`AXIL_ISO_RDATA, `AXIL_ISO_RESP_SLVERR);
    check_write_beat(`AXIL_ISO_RESP_SLVERR);
    check_val("downstream valid cycles", 32'(ds_valid_seen - seen_before), 32'd0);
    check_true(isolate_done, "isolate_done fell while isolate_req was still high");
  endtask

  task automatic resume_isolation();
    // The downstream subordinate comes back from reset with nothing pending
    flush_responder();
    hold = 1'b0;
    isolate_req = 1'b0;
    wait_done(1'b0);
    write_pass_through(12'h040, 32'hcafe_0001, 4'hf);
    read_pass_through(12'h044);
  endtask

  task automatic read_backpressure();
    hold = 1'b1;
    for (int i = 0; i < `AXIL_ISO_MAX_OUTSTANDING; i++) send_read(addr_t'(32'h100 + 4 * i));
    repeat (5) begin
      next_cycle();
      check_true(!arready, "arready stayed high at the outstanding limit");
    end
    hold = 1'b0;
    send_read(12'h200);
    wait_responses(`AXIL_ISO_MAX_OUTSTANDING + 1, 0);
    for (int i = 0; i < `AXIL_ISO_MAX_OUTSTANDING; i++) begin
      check_read_beat(data_t'(32'h1100 + 4 * i), RESP_OKAY);
    end
    check_read_beat(32'h1200, RESP_OKAY);
  endtask

  task automatic end_run(input bit timed_out);
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0 && !timed_out) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  endtask

  initial begin
    wait (cycles >= TIMEOUT_CYCLES);
    $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    end_run(1'b1);
  end

  initial begin
    checks = 0;
    errors = 0;
    ds_valid_seen = 0;
    rst_n = 1'b0;
    isolate_req = 1'b0;
    {awvalid, wvalid, arvalid} = 3'b000;
    {bready, rready} = 2'b11;
    awaddr = '0;
    araddr = '0;
    wdata = '0;
    wstrb = '0;
    hold = 1'b0;
    flush = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    next_cycle();
    write_pass_through(12'h104, 32'h1234_5678, 4'ha);
    read_pass_through(12'h208);
    isolate_with_pending();
    isolated_traffic();
    resume_isolation();
    read_backpressure();
    end_run(1'b0);
  end

endmodule

`default_nettype wire

//--- sim/axil_iso_asserts.sv
//**************************************************
// Concurrent protocol checks for the AXI4-Lite
// isolator and the bind into its top level
//**************************************************

`timescale 1ns/1ns
`default_nettype none

module axil_iso_asserts (
  input logic clk,
  input logic rst_n,
  input logic isolate_req,
  input logic isolate_done,
  input logic ds_awvalid,
  input logic ds_wvalid,
  input logic ds_arvalid,
  input logic bvalid,
  input logic bready,
  input logic rvalid,
  input logic rready
);

  // Done only moves after the request has changed
  done_follows_req: assert property (
    @(posedge clk) disable iff (!rst_n)
    (isolate_req == isolate_done) |=> $stable(isolate_done)
  ) else $error("isolate_done changed without a new isolate_req edge");

  no_ds_valid_when_done: assert property (
    @(posedge clk) disable iff (!rst_n)
    isolate_done |-> !(ds_awvalid || ds_wvalid || ds_arvalid)
  ) else $error("downstream valid raised while isolated");

  // An offered response waits for its handshake
  bvalid_held: assert property (
    @(posedge clk) disable iff (!rst_n)
    (bvalid && !bready) |=> bvalid
  ) else $error("bvalid dropped before the handshake");

  rvalid_held: assert property (
    @(posedge clk) disable iff (!rst_n)
    (rvalid && !rready) |=> rvalid
  ) else $error("rvalid dropped before the handshake");

endmodule

bind axil_sub_isolator axil_iso_asserts u_asserts (
  .clk(clk), .rst_n(rst_n), .isolate_req(isolate_req), .isolate_done(isolate_done),
  .ds_awvalid(ds_awvalid), .ds_wvalid(ds_wvalid), .ds_arvalid(ds_arvalid),
  .bvalid(bvalid), .bready(bready), .rvalid(rvalid), .rready(rready)
);

`default_nettype wire

//--- rtl/axil_sub_isolator.sv
//**************************************************
// AXI4-Lite subordinate isolator, top level.
// Holds the write and read paths and the combined
// isolate_done handshake register
//**************************************************

`timescale 1ns/1ns
`default_nettype none

module axil_sub_isolator
  import axil_iso_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  isolate_req,
  output logic  isolate_done,
  // Upstream manager side
  input  addr_t awaddr,
  input  logic  awvalid,
  output logic  awready,
  input  data_t wdata,
  input  strb_t wstrb,
  input  logic  wvalid,
  output logic  wready,
  output resp_t bresp,
  output logic  bvalid,
  input  logic  bready,
  input  addr_t araddr,
  input  logic  arvalid,
  output logic  arready,
  output data_t rdata,
  output resp_t rresp,
  output logic  rvalid,
  input  logic  rready,
  // Downstream subordinate side
  output addr_t ds_awaddr,
  output logic  ds_awvalid,
  input  logic  ds_awready,
  output data_t ds_wdata,
  output strb_t ds_wstrb,
  output logic  ds_wvalid,
  input  logic  ds_wready,
  input  resp_t ds_bresp,
  input  logic  ds_bvalid,
  output logic  ds_bready,
  output addr_t ds_araddr,
  output logic  ds_arvalid,
  input  logic  ds_arready,
  input  data_t ds_rdata,
  input  resp_t ds_rresp,
  input  logic  ds_rvalid,
  output logic  ds_rready
);

  logic wr_done;
  logic rd_done;

  wr_iso_path u_wr (
    .clk(clk), .rst_n(rst_n), .isolate_req(isolate_req),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .ds_awaddr(ds_awaddr), .ds_awvalid(ds_awvalid), .ds_awready(ds_awready),
    .ds_wdata(ds_wdata), .ds_wstrb(ds_wstrb), .ds_wvalid(ds_wvalid),
    .ds_wready(ds_wready), .ds_bresp(ds_bresp), .ds_bvalid(ds_bvalid),
    .ds_bready(ds_bready), .path_done(wr_done)
  );

  rd_iso_path u_rd (
    .clk(clk), .rst_n(rst_n), .isolate_req(isolate_req),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
    .ds_araddr(ds_araddr), .ds_arvalid(ds_arvalid), .ds_arready(ds_arready),
    .ds_rdata(ds_rdata), .ds_rresp(ds_rresp), .ds_rvalid(ds_rvalid),
    .ds_rready(ds_rready), .path_done(rd_done)
  );

  // Done rises when both directions are isolated and falls when both have left
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      isolate_done <= 1'b0;
    end else if (isolate_done) begin
      isolate_done <= wr_done || rd_done;
    end else begin
      isolate_done <= wr_done && rd_done;
    end
  end

endmodule

`default_nettype wire

//--- rtl/rd_iso_path.sv
//**************************************************
// Read direction of the isolator.
// Passes AR downstream, tracks it and returns R
// through an output register
//**************************************************

`timescale 1ns/1ns
`default_nettype none

`include "axil_iso_config.svh"

module rd_iso_path
  import axil_iso_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  isolate_req,
  input  addr_t araddr,
  input  logic  arvalid,
  output logic  arready,
  output data_t rdata,
  output resp_t rresp,
  output logic  rvalid,
  input  logic  rready,
  output addr_t ds_araddr,
  output logic  ds_arvalid,
  input  logic  ds_arready,
  input  data_t ds_rdata,
  input  resp_t ds_rresp,
  input  logic  ds_rvalid,
  output logic  ds_rready,
  output logic  path_done
);

  localparam int R_W = $bits(data_t) + $bits(resp_t);

  logic           isolating, idle;
  logic           r_valid, r_ready, r_local;
  logic [R_W-1:0] r_beat;

  iso_ctrl_fsm u_fsm (
    .clk(clk), .rst_n(rst_n), .isolate_req(isolate_req), .idle(idle),
    .isolating(isolating), .path_done(path_done)
  );

  iso_resp_tracker u_tracker (
    .clk(clk), .rst_n(rst_n), .isolating(isolating),
    .req_valid(arvalid), .req_ready(arready),
    .ds_req_valid(ds_arvalid), .ds_req_ready(ds_arready),
    .ds_resp_valid(ds_rvalid), .ds_resp_ready(ds_rready),
    .resp_valid(r_valid), .resp_ready(r_ready), .resp_local(r_local),
    .idle(idle)
  );

  assign ds_araddr = araddr;

  // Local beats carry the fixed pattern and SLVERR
  assign r_beat = r_local ?
                  {data_t'(`AXIL_ISO_RDATA), resp_t'(`AXIL_ISO_RESP_SLVERR)} :
                  {ds_rdata, ds_rresp};

  resp_out_reg #(.WIDTH(R_W)) u_r_reg (
    .clk(clk), .rst_n(rst_n),
    .in_valid(r_valid), .in_ready(r_ready), .in_data(r_beat),
    .out_valid(rvalid), .out_ready(rready), .out_data({rdata, rresp})
  );

endmodule

`default_nettype wire

//--- rtl/wr_iso_path.sv
//**************************************************
// Write direction of the isolator.
// Joins AW and W into one request, tracks it and
// returns B through an output register
//**************************************************

`timescale 1ns/1ns
`default_nettype none

`include "axil_iso_config.svh"

module wr_iso_path
  import axil_iso_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  isolate_req,
  input  addr_t awaddr,
  input  logic  awvalid,
  output logic  awready,
  input  data_t wdata,
  input  strb_t wstrb,
  input  logic  wvalid,
  output logic  wready,
  output resp_t bresp,
  output logic  bvalid,
  input  logic  bready,
  output addr_t ds_awaddr,
  output logic  ds_awvalid,
  input  logic  ds_awready,
  output data_t ds_wdata,
  output strb_t ds_wstrb,
  output logic  ds_wvalid,
  input  logic  ds_wready,
  input  resp_t ds_bresp,
  input  logic  ds_bvalid,
  output logic  ds_bready,
  output logic  path_done
);

  logic  isolating, idle;
  logic  req_valid, req_ready;
  logic  ds_req_valid, ds_req_ready;
  logic  b_valid, b_ready, b_local;
  resp_t b_resp;
  // Downstream halves already taken for the current write
  logic  aw_done, w_done;

  iso_ctrl_fsm u_fsm (
    .clk(clk), .rst_n(rst_n), .isolate_req(isolate_req), .idle(idle),
    .isolating(isolating), .path_done(path_done)
  );

  // The write enters only when address and data are both present
  assign req_valid = awvalid && wvalid;
  assign awready = req_valid && req_ready;
  assign wready = req_valid && req_ready;

  assign ds_awvalid = ds_req_valid && !aw_done;
  assign ds_wvalid = ds_req_valid && !w_done;
  assign ds_req_ready = (aw_done || ds_awready) && (w_done || ds_wready);

  always_ff @(posedge clk) begin
    if (!rst_n || (req_valid && req_ready)) begin
      aw_done <= 1'b0;
      w_done <= 1'b0;
    end else begin
      aw_done <= aw_done || (ds_awvalid && ds_awready);
      w_done <= w_done || (ds_wvalid && ds_wready);
    end
  end

  assign ds_awaddr = awaddr;
  assign ds_wdata = wdata;
  assign ds_wstrb = wstrb;

  iso_resp_tracker u_tracker (
    .clk(clk), .rst_n(rst_n), .isolating(isolating),
    .req_valid(req_valid), .req_ready(req_ready),
    .ds_req_valid(ds_req_valid), .ds_req_ready(ds_req_ready),
    .ds_resp_valid(ds_bvalid), .ds_resp_ready(ds_bready),
    .resp_valid(b_valid), .resp_ready(b_ready), .resp_local(b_local),
    .idle(idle)
  );

  assign b_resp = b_local ? resp_t'(`AXIL_ISO_RESP_SLVERR) : ds_bresp;

  resp_out_reg #(.WIDTH($bits(resp_t))) u_b_reg (
    .clk(clk), .rst_n(rst_n),
    .in_valid(b_valid), .in_ready(b_ready), .in_data(b_resp),
    .out_valid(bvalid), .out_ready(bready), .out_data(bresp)
  );

endmodule

`default_nettype wire

//--- rtl/resp_out_reg.sv
//**************************************************
// One-entry forward register for an upstream
// response channel, full throughput
//**************************************************

`timescale 1ns/1ns
`default_nettype none

module resp_out_reg #(
  parameter int WIDTH = 2
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             in_valid,
  output logic             in_ready,
  input  logic [WIDTH-1:0] in_data,
  output logic             out_valid,
  input  logic             out_ready,
  output logic [WIDTH-1:0] out_data
);

  logic             full;
  logic [WIDTH-1:0] data_q;

  // A new entry may enter on the same cycle the old one leaves
  assign in_ready = !full || out_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      full <= 1'b0;
    end else if (in_valid && in_ready) begin
      full <= 1'b1;
    end else if (out_ready) begin
      full <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      data_q <= in_data;
    end
  end

  assign out_valid = full;
  assign out_data = data_q;

endmodule

`default_nettype wire

//--- rtl/iso_resp_tracker.sv
//**************************************************
// Response tracker for one direction.
// Counts requests waiting for a response, gates
// the downstream request and response handshakes,
// and makes local responses while isolating
//**************************************************

`timescale 1ns/1ns
`default_nettype none

`include "axil_iso_config.svh"

module iso_resp_tracker
  import axil_iso_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic isolating,
  // Upstream request
  input  logic req_valid,
  output logic req_ready,
  // Downstream request
  output logic ds_req_valid,
  input  logic ds_req_ready,
  // Downstream response
  input  logic ds_resp_valid,
  output logic ds_resp_ready,
  // Upstream response, toward the output register
  output logic resp_valid,
  input  logic resp_ready,
  output logic resp_local,
  output logic idle
);

  cnt_t count;
  logic at_limit;
  logic req_fire;
  logic resp_fire;

  assign at_limit = (count == cnt_t'(`AXIL_ISO_MAX_OUTSTANDING));

  // Requests are held back at the limit in both modes
  assign ds_req_valid = req_valid && !at_limit && !isolating;
  assign req_ready = isolating ? !at_limit : (ds_req_ready && !at_limit);

  // While isolating, downstream responses are taken and thrown away
  assign ds_resp_ready = isolating ? 1'b1 : resp_ready;

  // One local response for every request still counted
  assign resp_valid = isolating ? (count != '0) : ds_resp_valid;
  assign resp_local = isolating;

  assign idle = (count == '0) && !resp_valid;

  assign req_fire = req_valid && req_ready;
  assign resp_fire = resp_valid && resp_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      count <= '0;
    end else if (req_fire && !resp_fire) begin
      count <= count + cnt_t'(1);
    end else if (!req_fire && resp_fire) begin
      count <= count - cnt_t'(1);
    end
  end

endmodule

`default_nettype wire

//--- rtl/iso_ctrl_fsm.sv
//**************************************************
// Isolation control FSM for one direction.
// Enters isolation on isolate_req, waits for the
// tracker to drain, and leaves isolation only once
// all local responses are gone
//**************************************************

`timescale 1ns/1ns
`default_nettype none

module iso_ctrl_fsm
  import axil_iso_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic isolate_req,
  input  logic idle,
  output logic isolating,
  output logic path_done
);

  iso_state_t state;
  iso_state_t state_next;

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (isolate_req) begin
          state_next = DRAIN;
        end
      end
      // Pending requests get local answers until none is left
      DRAIN: begin
        if (idle) begin
          state_next = ISOLATED;
        end
      end
      ISOLATED: begin
        if (!isolate_req) begin
          state_next = RESUME;
        end
      end
      // Requests taken while isolated must still be answered locally
      RESUME: begin
        if (idle) begin
          state_next = IDLE;
        end
      end
      default: begin
        state_next = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  assign isolating = (state != IDLE);
  assign path_done = (state == ISOLATED);

endmodule

`default_nettype wire

//--- rtl/axil_iso_pkg.sv
//**************************************************
// Shared types of the AXI4-Lite isolator:
// bus field vectors, the outstanding counter and
// the isolation state encoding
//**************************************************

`default_nettype none

`include "axil_iso_config.svh"

package axil_iso_pkg;

  // Bus fields
  typedef logic [`AXIL_ISO_ADDR_W-1:0] addr_t;
  typedef logic [`AXIL_ISO_DATA_W-1:0] data_t;
  typedef logic [`AXIL_ISO_DATA_W/8-1:0] strb_t;
  typedef logic [1:0] resp_t;

  // Requests still waiting for a response
  typedef logic [`AXIL_ISO_CNT_W-1:0] cnt_t;

  // Per-direction isolation control
  typedef enum logic [1:0] {
    IDLE,
    DRAIN,
    ISOLATED,
    RESUME
  } iso_state_t;

endpackage

`default_nettype wire

//--- rtl/axil_iso_config.svh
//**************************************************
// Build-time settings of the AXI4-Lite isolator:
// bus widths, the outstanding request limit per
// direction and the values returned for requests
// that are answered during isolation
//**************************************************

`ifndef AXIL_ISO_CONFIG_SVH
`define AXIL_ISO_CONFIG_SVH

// Bus widths
`define AXIL_ISO_ADDR_W 12
`define AXIL_ISO_DATA_W 32

// Requests that may wait for a response in each direction
`define AXIL_ISO_MAX_OUTSTANDING 8

// Must hold the value AXIL_ISO_MAX_OUTSTANDING itself
`define AXIL_ISO_CNT_W 4

// Response code and read data for isolated transactions
`define AXIL_ISO_RESP_SLVERR 2'b10
`define AXIL_ISO_RDATA 32'hdead_beef

`endif
